//--- hdl/arb_hold_weighted_rr.sv
`default_nettype none
`timescale 1ns/100ps

module arb_hold_weighted_rr
  import arb_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         enable_priority_update,
  input  req_vec_t                     request,
  // Configured weight of every requester
  input  weight_t [num_requesters-1:0] weights,
  // Keep the current grant while this bit stays high
  input  req_vec_t                     grant_hold,
  // Final one-hot or zero grant
  output req_vec_t                     grant
);

  // --------------------------------------------------
  // Weighted arbiter
  // --------------------------------------------------

  // Update enable after the hold gating
  logic     enable_priority_update_int;
  // Grant as the weighted arbiter would give it without any hold
  req_vec_t grant_pre;
  // Final grant of the previous cycle
  req_vec_t grant_last;
  // Hold request that matches the requester granted last cycle
  req_vec_t hold;

  arb_weighted_rr u_arb_weighted_rr (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update_int),
    .request                (request),
    .weights                (weights),
    .grant                  (grant_pre)
  );

  // --------------------------------------------------
  // Grant hold
  // --------------------------------------------------

  // The final grant is registered every cycle, held or not
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_last <= '0;
    end else begin
      grant_last <= grant;
    end
  end

  // A hold bit on a requester that was not granted has no effect
  assign hold = grant_hold & grant_last;

  // During a hold the state is frozen so arbitration resumes
  // from the same point once the hold is released
  assign enable_priority_update_int = enable_priority_update && !(|hold);

  // The held grant stays even if its request has dropped
  assign grant = (|hold) ? hold : grant_pre;

endmodule : arb_hold_weighted_rr

`default_nettype wire

//--- hdl/arb_pkg.sv
`default_nettype none

package arb_pkg;

  // --------------------------------------------------
  // Arbiter sizes
  // --------------------------------------------------

  // Number of requesters that compete for the grant
  localparam int num_requesters = 4;

  // Largest weight that a requester can be given
  localparam int max_weight = 7;

  // Saturation value of each weight accumulator
  // It must not be below max_weight or a refill could lose weight
  localparam int max_accumulated_weight = 14;

  // Bits needed to hold any weight from zero to max_weight
  localparam int weight_width = $clog2(max_weight + 1);

  // Bits needed to hold any accumulator value up to saturation
  localparam int accum_width = $clog2(max_accumulated_weight + 1);

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  // One bit per requester for request, grant, hold and priority masks
  typedef logic [num_requesters-1:0] req_vec_t;

  // Configured weight of one requester
  typedef logic [weight_width-1:0] weight_t;

  // Weight accumulator of one requester
  typedef logic [accum_width-1:0] accum_t;

  // Index of one requester
  typedef logic [$clog2(num_requesters)-1:0] req_idx_t;

  // Every requester starts with this weight after reset
  localparam weight_t reset_weight = weight_t'(1);

endpackage : arb_pkg

`default_nettype wire

//--- hdl/arb_top.sv
`default_nettype none
`timescale 1ns/100ps

module arb_top
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // --------------------------------------------------
  // Weight configuration
  // --------------------------------------------------

  // Writes cfg_weight into slot cfg_idx on the edge where cfg_we is high
  input  logic     cfg_we,
  input  req_idx_t cfg_idx,
  input  weight_t  cfg_weight,

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------

  // Low freezes the accumulators and the pointer
  input  logic     enable_priority_update,
  // One level per requester
  input  req_vec_t request,
  // Keep a granted requester in place while its bit is high
  input  req_vec_t grant_hold,
  // One-hot or zero, combinational from the inputs and the state
  output req_vec_t grant
);

  // Current weights from the configuration bank
  weight_t [num_requesters-1:0] weights;

  // --------------------------------------------------
  // Configuration bank
  // --------------------------------------------------

  // Weights are registered here so a write takes effect
  // in the arbitration of the following cycle
  weight_config_regs u_weight_config_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .cfg_idx    (cfg_idx),
    .cfg_weight (cfg_weight),
    .weights    (weights)
  );

  // --------------------------------------------------
  // Arbiter with grant hold
  // --------------------------------------------------

  // With no request and no prior grant the output is zero
  // which is the case while reset is applied
  arb_hold_weighted_rr u_arb_hold_weighted_rr (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .weights                (weights),
    .grant_hold             (grant_hold),
    .grant                  (grant)
  );

endmodule : arb_top

`default_nettype wire

//--- hdl/arb_weighted_rr.sv
`default_nettype none
`timescale 1ns/100ps

module arb_weighted_rr
  import arb_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // Allow accumulators and pointer to change on a grant
  input  logic                         enable_priority_update,
  input  req_vec_t                     request,
  // Configured weight of every requester
  input  weight_t [num_requesters-1:0] weights,
  // One-hot or zero grant
  output req_vec_t                     grant
);

  // --------------------------------------------------
  // Accumulators and priority
  // --------------------------------------------------

  // Saturating weight accumulator per requester
  accum_t [num_requesters-1:0] accum;

  // Accumulator values to load on the next update
  accum_t [num_requesters-1:0] accum_next;

  // Priority bit per requester, set while its accumulator is non-zero
  req_vec_t prio;

  // Requests that are active and hold priority 1
  req_vec_t high_request;

  // All accumulators are refilled when the grantee has run dry
  logic refill;

  // State changes only on an allowed update with an actual grant
  logic accum_we;

  for (genvar i = 0; i < num_requesters; i++) begin : g_prio
    assign prio[i] = (accum[i] != '0);
  end : g_prio

  assign high_request = request & prio;

  // --------------------------------------------------
  // Round-robin selection
  // --------------------------------------------------

  // The select block owns the pointer and moves it on the same update
  // that changes the accumulators
  rr_priority_select u_rr_priority_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .update       (enable_priority_update),
    .high_request (high_request),
    .request      (request),
    .grant        (grant)
  );

  // --------------------------------------------------
  // Refill and decrement
  // --------------------------------------------------

  // The grant is one-hot so this picks out the grantee's priority bit
  // A grantee with priority 0 has an empty accumulator
  assign refill = |(grant & ~prio);

  assign accum_we = enable_priority_update && (|grant);

  for (genvar i = 0; i < num_requesters; i++) begin : g_accum

    // One extra bit so the sum cannot wrap before saturation
    logic [accum_width:0] sum;
    accum_t               refilled;
    accum_t               base;

    // Add the weight and clamp at the saturation value
    assign sum = {1'b0, accum[i]} + (accum_width + 1)'(weights[i]);
    assign refilled = (sum > (accum_width + 1)'(max_accumulated_weight)) ?
                      accum_t'(max_accumulated_weight) : sum[accum_width-1:0];

    // Refill first, then take one from the grantee
    assign base = refill ? refilled : accum[i];

    // A grantee with zero weight stays at zero instead of wrapping
    assign accum_next[i] = (grant[i] && (base != '0)) ? base - accum_t'(1) : base;

  end : g_accum

  // Accumulators are empty after reset so every requester
  // starts with priority 0 and the first grant triggers a refill
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      accum <= '0;
    end else if (accum_we) begin
      accum <= accum_next;
    end
  end

  // A requester with zero weight never leaves priority 0
  // It can still win when no priority-1 request is active

endmodule : arb_weighted_rr

`default_nettype wire

//--- hdl/rr_priority_select.sv
`default_nettype none
`timescale 1ns/100ps

module rr_priority_select
  import arb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Move the pointer to the grantee at the next edge
  input  logic     update,
  // Requests that currently hold priority 1
  input  req_vec_t high_request,
  // All active requests
  input  req_vec_t request,
  // One-hot or zero grant
  output req_vec_t grant
);

  // --------------------------------------------------
  // Last-grant pointer
  // --------------------------------------------------

  // Index of the requester that was granted last
  // The search always starts one place after it
  req_idx_t ptr;

  // Result of the two searches
  logic     found_high;
  logic     found_any;
  req_idx_t high_idx;
  req_idx_t any_idx;

  // Final choice of the two searches
  logic     sel_valid;
  req_idx_t sel_idx;

  // --------------------------------------------------
  // Round-robin search
  // --------------------------------------------------

  // Both searches walk the same order starting after the pointer
  // and wrapping around, so the pointer itself is checked last
  // The first hit in each search is kept
  always_comb begin
    found_high = 1'b0;
    found_any  = 1'b0;
    high_idx   = '0;
    any_idx    = '0;
    for (int k = 1; k <= num_requesters; k++) begin
      req_idx_t cand;
      cand = req_idx_t'((int'(ptr) + k) % num_requesters);
      if (!found_high && high_request[cand]) begin
        found_high = 1'b1;
        high_idx   = cand;
      end
      if (!found_any && request[cand]) begin
        found_any = 1'b1;
        any_idx   = cand;
      end
    end
  end

  // Priority-1 requests win over the rest
  // high_request is a subset of request so any hit there is also a hit in the second search
  assign sel_valid = found_any;
  assign sel_idx   = found_high ? high_idx : any_idx;

  // Decode the chosen index into a one-hot grant
  // With no request the grant stays zero
  always_comb begin
    grant = '0;
    if (sel_valid) begin
      grant[sel_idx] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Pointer update
  // --------------------------------------------------

  // Out of reset the pointer sits on the last index
  // so requester 0 is the first one looked at
  // It only moves when an update is allowed and a grant is made
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= req_idx_t'(num_requesters - 1);
    end else if (update && (|grant)) begin
      ptr <= sel_idx;
    end
  end

endmodule : rr_priority_select

`default_nettype wire

//--- hdl/weight_config_regs.sv
`default_nettype none
`timescale 1ns/100ps

module weight_config_regs
  import arb_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // Write strobe for one weight slot
  input  logic                         cfg_we,
  input  req_idx_t                     cfg_idx,
  input  weight_t                      cfg_weight,
  // Current weight of every requester
  output weight_t [num_requesters-1:0] weights
);

  // --------------------------------------------------
  // Slot decode
  // --------------------------------------------------

  // One write enable per slot, taken from the strobe and the index
  req_vec_t slot_we;

  always_comb begin
    slot_we = '0;
    if (cfg_we) begin
      slot_we[cfg_idx] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Weight registers
  // --------------------------------------------------

  // Each slot is a plain register that loads on its own enable
  // The new weight is seen by the arbiter from the next cycle on
  // A value above max_weight cannot be written since the field is too narrow for it
  for (genvar i = 0; i < num_requesters; i++) begin : g_slot

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        // All requesters share the same weight out of reset
        weights[i] <= reset_weight;
      end else if (slot_we[i]) begin
        weights[i] <= cfg_weight;
      end
    end

  end : g_slot

  // A zero weight is legal and simply keeps that requester
  // out of the priority-1 group
  // Writes to one slot leave every other slot untouched

endmodule : weight_config_regs

`default_nettype wire

//--- testbench/arb_assert.sv
`default_nettype none
`timescale 1ns/100ps

module arb_assert
  import arb_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input req_vec_t request,
  input req_vec_t grant_hold,
  // Hold bits that match the grant of the previous cycle
  input req_vec_t hold,
  input req_vec_t grant
);

  // --------------------------------------------------
  // Grant shape
  // --------------------------------------------------

  // At most one requester owns the grant
  a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else $error("grant has more than one bit set");

  // A grant goes to a requester that asks for it or that keeps a held grant
  a_grant_source : assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~(request | hold)) == '0)
    else $error("grant given to a requester that neither requests nor holds");

  // --------------------------------------------------
  // Hold behavior
  // --------------------------------------------------

  // Once a hold is active the grant stays put as long as the holder keeps its bit high
  a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (|hold) |=> (((grant_hold & $past(grant)) == '0) || (grant == $past(grant))))
    else $error("held grant moved while its hold bit stayed high");

endmodule : arb_assert

bind arb_hold_weighted_rr arb_assert u_arb_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .request    (request),
  .grant_hold (grant_hold),
  .hold       (hold),
  .grant      (grant)
);

`default_nettype wire

//--- testbench/arb_tb.sv
`default_nettype none
`timescale 1ns/100ps

module arb_tb import arb_pkg::*; ();

  logic     clk = 1'b0;
  logic     rst_n;
  logic     rst_next;
  logic     cfg_we;
  req_idx_t cfg_idx;
  weight_t  cfg_weight;
  logic     enable_priority_update;
  req_vec_t request;
  req_vec_t grant_hold;
  req_vec_t grant;

  integer   seed;

  // Reference model state
  int       m_weight [num_requesters];
  int       m_accum  [num_requesters];
  int       m_count  [num_requesters];
  int       d_count  [num_requesters];
  int       m_ptr;
  req_vec_t m_last;
  // Per-cycle snapshots taken just before the rising edge
  req_vec_t m_grant;
  req_vec_t m_prio;
  req_vec_t m_held;
  req_vec_t d_grant;

  arb_top uut (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .cfg_we                 (cfg_we),
    .cfg_idx                (cfg_idx),
    .cfg_weight             (cfg_weight),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .grant_hold             (grant_hold),
    .grant                  (grant)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  task automatic reset_model();
    for (int i = 0; i < num_requesters; i++) begin
      m_weight[i] = reset_weight;
      m_accum[i]  = 0;
    end
    // Pointer on the last index so requester 0 is searched first
    m_ptr  = num_requesters - 1;
    m_last = '0;
  endtask

  // Held grant first, then priority-1 requests after the pointer, then any request
  function automatic req_vec_t model_grant(input req_vec_t req, input req_vec_t hold_in);
    req_vec_t held;
    int       idx;
    held = hold_in & m_last;
    if (held != '0) return held;
    for (int k = 1; k <= num_requesters; k++) begin
      idx = (m_ptr + k) % num_requesters;
      if (req[idx] && m_accum[idx] != 0) return req_vec_t'(1) << idx;
    end
    for (int k = 1; k <= num_requesters; k++) begin
      idx = (m_ptr + k) % num_requesters;
      if (req[idx]) return req_vec_t'(1) << idx;
    end
    return '0;
  endfunction

  // Refill everybody when the grantee is empty, then charge the grantee one credit
  task automatic update_model(input req_vec_t g);
    int gi;
    int sum;
    gi = 0;
    for (int i = 0; i < num_requesters; i++) begin
      if (g[i]) gi = i;
    end
    if (m_accum[gi] == 0) begin
      for (int i = 0; i < num_requesters; i++) begin
        sum        = m_accum[i] + m_weight[i];
        m_accum[i] = (sum > max_accumulated_weight) ? max_accumulated_weight : sum;
      end
    end
    if (m_accum[gi] > 0) m_accum[gi]--;
    m_ptr = gi;
  endtask

  // --------------------------------------------------
  // One clock cycle
  // --------------------------------------------------

  // Drive on the falling edge, compare 1 ns before the rising edge, then step the model
  task automatic run_cycle(input logic we, input int idx, input int w, input logic epu,
                           input req_vec_t req, input req_vec_t hold_in);
    @(negedge clk);
    rst_n                  = rst_next;
    cfg_we                 = we;
    cfg_idx                = req_idx_t'(idx);
    cfg_weight             = weight_t'(w);
    enable_priority_update = epu;
    request                = req;
    grant_hold             = hold_in;
    #1;
    m_grant = model_grant(req, hold_in);
    m_held  = hold_in & m_last;
    d_grant = grant;
    for (int i = 0; i < num_requesters; i++) begin
      m_prio[i] = (m_accum[i] != 0);
    end
    check_value("grant", m_grant, d_grant);
    @(posedge clk);
    if (!rst_n) begin
      reset_model();
    end else begin
      // A held cycle leaves the accumulators and pointer alone
      if (epu && m_held == '0 && m_grant != '0) update_model(m_grant);
      m_last = m_grant;
      if (we) m_weight[idx] = w;
      for (int i = 0; i < num_requesters; i++) begin
        if (m_grant[i]) m_count[i]++;
        if (d_grant[i]) d_count[i]++;
      end
    end
  endtask

  task automatic wait_for_grant(input logic epu, input req_vec_t req, input int limit);
    int n;
    n = 0;
    run_cycle(1'b0, 0, 0, epu, req, '0);
    while (m_grant == '0) begin
      n++;
      if (n >= limit) abort_run("Timed out waiting for the arbiter to issue a grant");
      else run_cycle(1'b0, 0, 0, epu, req, '0);
    end
  endtask

  task automatic clear_counts();
    for (int i = 0; i < num_requesters; i++) begin
      m_count[i] = 0;
      d_count[i] = 0;
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    logic [31:0] r;
    req_vec_t    first;
    int          share;
    seed                   = 32'hdfc394c5;
    rst_n                  = 1'b0;
    rst_next               = 1'b0;
    cfg_we                 = 1'b0;
    cfg_idx                = '0;
    cfg_weight             = '0;
    enable_priority_update = 1'b0;
    request                = '0;
    grant_hold             = '0;
    reset_model();
    clear_counts();

    // Reset for 5 cycles with no requests, so grant must stay zero
    // The first rising edge already falls inside reset before the loop starts
    for (int i = 0; i < 4; i++) run_cycle(1'b0, 0, 0, 1'b0, '0, '0);
    rst_next = 1'b1;

    // Equal weights give a plain rotation starting at requester 0
    wait_for_grant(1'b1, '1, 8);
    check_value("first_grant", 1, d_grant);
    for (int k = 1; k < 12; k++) begin
      run_cycle(1'b0, 0, 0, 1'b1, '1, '0);
      check_value("rotation_grant", 1 << (k % num_requesters), d_grant);
    end

    // Weights 1..4, then a long run with every requester busy
    for (int i = 0; i < num_requesters; i++) run_cycle(1'b1, i, i + 1, 1'b0, '0, '0);
    clear_counts();
    for (int k = 0; k < 400; k++) run_cycle(1'b0, 0, 0, 1'b1, '1, '0);
    for (int i = 0; i < num_requesters; i++) begin
      check_value("grant_count", m_count[i], d_count[i]);
      // Each refill round hands out every weight once, so the share follows 1:2:3:4
      share = 400 * (i + 1) / (num_requesters * (num_requesters + 1) / 2);
      check_value("count_share", 1,
                  (d_count[i] >= share - (i + 1)) && (d_count[i] <= share + (i + 1)));
    end

    // Random requests, writes and update enables, zero weights included
    for (int k = 0; k < 600; k++) begin
      r = $random(seed);
      run_cycle(r[0] & r[1], r[3:2], r[6:4], r[7] | r[8], r[12:9], '0);
      // A priority-0 winner means no priority-1 request was waiting
      if ((d_grant & ~m_prio) != '0) check_value("high_request", 0, request & m_prio);
    end

    // Updates off freeze the state, so the grant repeats
    r = $random(seed);
    wait_for_grant(1'b0, r[3:0] | 4'b0100, 8);
    first = m_grant;
    for (int k = 0; k < 20; k++) begin
      run_cycle(1'b0, 0, 0, 1'b0, r[3:0] | 4'b0100, '0);
      check_value("frozen_grant", first, d_grant);
    end

    // Random holds on top of random traffic
    for (int k = 0; k < 600; k++) begin
      r = $random(seed);
      run_cycle(r[0] & r[1] & r[2], r[4:3], r[7:5], r[8] | r[9], r[13:10],
                r[17:14] | r[21:18]);
      if (m_held != '0) check_value("held_grant", m_held, d_grant);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule : arb_tb

`default_nettype wire

//--- vlog.f
hdl/arb_pkg.sv
hdl/weight_config_regs.sv
hdl/rr_priority_select.sv
hdl/arb_weighted_rr.sv
hdl/arb_hold_weighted_rr.sv
hdl/arb_top.sv
testbench/arb_assert.sv
testbench/arb_tb.sv
